// ==== hdl/pxct_pkg.sv ====
package pxct_pkg;

   // Special-function selector, shared by the EN_10 and EN_20 groups
   typedef enum logic [3:0]
   {
      SPEC_NOP     = 4'h0,
      SPEC_SPARE1  = 4'h1,
      SPEC_SPARE2  = 4'h2,
      SPEC_SPARE3  = 4'h3,
      SPEC_PXCTEN  = 4'h7,              // Load mask, context on
      SPEC_PXCTOFF = 4'hf               // Load mask, context off
   } spec_sel_e;

   // Memory reference selector
   typedef enum logic [2:0]
   {
      REF_CURRENT = 3'd0,               // Always current context
      REF_E1      = 3'd1,               // First effective address
      REF_UNUSED  = 3'd2,
      REF_D1      = 3'd3,               // First data
      REF_BIS_SRC = 3'd4,               // Byte string source
      REF_E2      = 3'd5,
      REF_BIS_DST = 3'd6,               // Byte string destination
      REF_D2      = 3'd7
   } ref_sel_e;

   localparam int DP_W          = 36;   // Data path, bit 0 is the MSB
   localparam int ADDR_W        = 18;
   localparam int ACB_W         = 3;    // AC block number
   localparam int AC_ADDR_LIMIT = 16;   // Addresses below this are ACs
   localparam int AC_IDX_W      = $clog2(AC_ADDR_LIMIT);

   // PXCT mask field in dp
   localparam int PXCT_LSB = 9;
   localparam int PXCT_MSB = 12;

   // Register block
   localparam int WB_AW = 2;
   localparam int WB_DW = 8;
   localparam logic [WB_AW-1:0] REG_CUR_CTX  = 2'd0;
   localparam logic [WB_AW-1:0] REG_PREV_CTX = 2'd1;

   // Context register layout
   localparam int CTX_USER_BIT = 3;
   localparam int CTX_ACB_LSB  = 0;     // ACB in bits 2..0
   localparam int CTX_W        = CTX_USER_BIT + 1;

endpackage

// ==== hdl/pxct_ctl.sv ====
`timescale 1ns/1ps

module pxct_ctl
(
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic                                             clken,
   input  logic                                             spec_en10,
   input  logic                                             spec_en20,
   input  pxct_pkg::spec_sel_e                              spec_sel,
   input  logic [0:pxct_pkg::DP_W-1]                        dp,
   input  pxct_pkg::ref_sel_e                               ref_sel,
   input  logic                                             wru_cycle,
   output logic                                             pxct_on,
   output logic [pxct_pkg::PXCT_LSB:pxct_pkg::PXCT_MSB]     pxct,
   output logic                                             previous_en
);
   import pxct_pkg::*;

   logic pxct_en;                       // PXCTEN decode, EN_10 group
   logic pxct_off;                      // PXCTOFF decode, EN_20 group
   logic pxct_ld;

   //////////////////////////////////////////////////////////////////////
   // PXCT register
   //////////////////////////////////////////////////////////////////////

   assign pxct_en  = spec_en10 & (spec_sel == SPEC_PXCTEN);
   assign pxct_off = spec_en20 & (spec_sel == SPEC_PXCTOFF);
   assign pxct_ld  = clken & (pxct_en | pxct_off);   // Off code loads too

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pxct_on <= 1'b0;
         pxct    <= '0;
      end
      else if (pxct_ld)
      begin
         pxct_on <= ~pxct_off;
         pxct    <= dp[PXCT_LSB:PXCT_MSB];           // Mask straight off dp
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Previous-context enable
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      previous_en = 1'b0;
      // Gated by bit 9 or a write-user cycle
      if (pxct_on & (pxct[PXCT_LSB] | wru_cycle))
      begin
         case (ref_sel)
            REF_CURRENT : previous_en = 1'b0;
            REF_E1      : previous_en = pxct[PXCT_LSB];
            REF_UNUSED,
            REF_D1      : previous_en = pxct[PXCT_LSB+1];
            REF_BIS_SRC,
            REF_E2      : previous_en = pxct[PXCT_LSB+2];
            REF_BIS_DST,
            REF_D2      : previous_en = pxct[PXCT_MSB];
            default     : previous_en = 1'b0;
         endcase
      end
   end

   // Turn-off is a load of its own, EN_10 stays quiet alongside it
   a_off_alone : assert property (@(posedge clk) disable iff (rst)
      (clken && pxct_off) |-> !spec_en10);

endmodule

// ==== hdl/ctx_regs.sv ====
`timescale 1ns/1ps

module ctx_regs
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [pxct_pkg::WB_AW-1:0]    wb_adr,
   input  logic [pxct_pkg::WB_DW-1:0]    wb_dat_w,
   output logic [pxct_pkg::WB_DW-1:0]    wb_dat_r,
   output logic                          wb_ack,
   output logic [pxct_pkg::ACB_W-1:0]    cur_acb,
   output logic                          cur_user,
   output logic [pxct_pkg::ACB_W-1:0]    prev_acb,
   output logic                          prev_user
);
   import pxct_pkg::*;

   logic [CTX_W-1:0] cur_ctx;           // {user, acb}
   logic [CTX_W-1:0] prev_ctx;
   logic             wb_hit;            // New access, not yet acked
   logic [WB_DW-1:0] rd_data;

   // One ack per stb, master drops stb after it
   assign wb_hit = wb_cyc & wb_stb & ~wb_ack;

   //////////////////////////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (wb_adr)
         REG_CUR_CTX  : rd_data = WB_DW'(cur_ctx);   // Upper bits zero
         REG_PREV_CTX : rd_data = WB_DW'(prev_ctx);
         default      : rd_data = '0;                // Unmapped
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (wb_hit)
         wb_dat_r <= rd_data;           // Valid alongside ack
   end

   //////////////////////////////////////////////////////////////////////
   // Ack and context registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wb_ack   <= 1'b0;
         cur_ctx  <= '0;
         prev_ctx <= '0;
      end
      else
      begin
         wb_ack <= wb_hit;
         if (wb_hit & wb_we)
         begin
            // Write lands on the ack edge
            if (wb_adr == REG_CUR_CTX)
               cur_ctx <= wb_dat_w[CTX_W-1:0];
            else if (wb_adr == REG_PREV_CTX)
               prev_ctx <= wb_dat_w[CTX_W-1:0];
         end
      end
   end

   // Field split for the map stage
   assign cur_acb   = cur_ctx[CTX_ACB_LSB +: ACB_W];
   assign cur_user  = cur_ctx[CTX_USER_BIT];
   assign prev_acb  = prev_ctx[CTX_ACB_LSB +: ACB_W];
   assign prev_user = prev_ctx[CTX_USER_BIT];

   a_ack_single : assert property (@(posedge clk) disable iff (rst)
      wb_ack |=> !wb_ack);

   // No ack without a strobe the cycle before
   a_ack_after_stb : assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

// ==== hdl/ctx_map.sv ====
`timescale 1ns/1ps

module ctx_map
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  logic                          mem_req,
   input  logic [pxct_pkg::ADDR_W-1:0]   mem_addr,
   input  logic                          previous_en,
   input  logic [pxct_pkg::ACB_W-1:0]    cur_acb,
   input  logic [pxct_pkg::ACB_W-1:0]    prev_acb,
   input  logic                          cur_user,
   input  logic                          prev_user,
   output logic                          map_valid,
   output logic [pxct_pkg::ADDR_W-1:0]   map_addr,
   output logic                          map_user,
   output logic                          map_ac
);
   import pxct_pkg::*;

   logic [ACB_W-1:0] sel_acb;           // Chosen context
   logic             sel_user;
   logic             is_ac;             // AC reference

   assign sel_acb  = previous_en ? prev_acb  : cur_acb;
   assign sel_user = previous_en ? prev_user : cur_user;
   assign is_ac    = (mem_addr < ADDR_W'(AC_ADDR_LIMIT));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         map_valid <= 1'b0;
      else
         map_valid <= clken & mem_req;  // One cycle per reference
   end

   // Payload, no back-pressure so it follows every accept
   always_ff @(posedge clk)
   begin
      if (clken & mem_req)
      begin
         map_user <= sel_user;
         map_ac   <= is_ac;
         if (is_ac)
            map_addr <= ADDR_W'({sel_acb, mem_addr[AC_IDX_W-1:0]});   // Into AC block
         else
            map_addr <= mem_addr;
      end
   end

   // Nothing in flight across reset release
   a_quiet_after_rst : assert property (@(posedge clk)
      $fell(rst) |-> !map_valid);

endmodule

// ==== hdl/pxct_unit.sv ====
`timescale 1ns/1ps

module pxct_unit
(
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic                                             clken,
   // Microcode fields
   input  logic                                             spec_en10,
   input  logic                                             spec_en20,
   input  pxct_pkg::spec_sel_e                              spec_sel,
   input  logic [0:pxct_pkg::DP_W-1]                        dp,
   // Memory request
   input  logic                                             mem_req,
   input  logic [pxct_pkg::ADDR_W-1:0]                      mem_addr,
   input  pxct_pkg::ref_sel_e                               ref_sel,
   input  logic                                             wru_cycle,
   // Wishbone slave
   input  logic                                             wb_cyc,
   input  logic                                             wb_stb,
   input  logic                                             wb_we,
   input  logic [pxct_pkg::WB_AW-1:0]                       wb_adr,
   input  logic [pxct_pkg::WB_DW-1:0]                       wb_dat_w,
   output logic [pxct_pkg::WB_DW-1:0]                       wb_dat_r,
   output logic                                             wb_ack,
   // Mapped reference
   output logic                                             map_valid,
   output logic [pxct_pkg::ADDR_W-1:0]                      map_addr,
   output logic                                             map_user,
   output logic                                             map_ac,
   // PXCT status
   output logic                                             pxct_on,
   output logic [pxct_pkg::PXCT_LSB:pxct_pkg::PXCT_MSB]     pxct
);
   import pxct_pkg::*;

   logic [ACB_W-1:0] cur_acb;
   logic [ACB_W-1:0] prev_acb;
   logic             cur_user;
   logic             prev_user;
   logic             previous_en;       // Use previous context

   pxct_ctl u_pxct_ctl
   (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .spec_en10   (spec_en10),
      .spec_en20   (spec_en20),
      .spec_sel    (spec_sel),
      .dp          (dp),
      .ref_sel     (ref_sel),
      .wru_cycle   (wru_cycle),
      .pxct_on     (pxct_on),
      .pxct        (pxct),
      .previous_en (previous_en)
   );

   ctx_regs u_ctx_regs
   (
      .clk       (clk),
      .rst       (rst),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .cur_acb   (cur_acb),
      .cur_user  (cur_user),
      .prev_acb  (prev_acb),
      .prev_user (prev_user)
   );

   ctx_map u_ctx_map
   (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .mem_req     (mem_req),
      .mem_addr    (mem_addr),
      .previous_en (previous_en),
      .cur_acb     (cur_acb),
      .prev_acb    (prev_acb),
      .cur_user    (cur_user),
      .prev_user   (prev_user),
      .map_valid   (map_valid),
      .map_addr    (map_addr),
      .map_user    (map_user),
      .map_ac      (map_ac)
   );

endmodule

// ==== bench/pxct_checker.sv ====
`timescale 1ns/1ps

module pxct_checker
(
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic                                             report,
   // Expected record, one cycle wide
   input  logic                                             exp_stb,
   input  logic [3:0]                                       exp_op,
   input  int                                               exp_id,
   input  logic [7:0]                                       exp_x,
   input  logic [3:0]                                       exp_y,
   input  logic [pxct_pkg::ADDR_W-1:0]                      exp_z,
   // DUT outputs
   input  logic                                             wb_ack,
   input  logic [pxct_pkg::WB_DW-1:0]                       wb_dat_r,
   input  logic                                             map_valid,
   input  logic [pxct_pkg::ADDR_W-1:0]                      map_addr,
   input  logic                                             map_user,
   input  logic                                             map_ac,
   input  logic                                             pxct_on,
   input  logic [pxct_pkg::PXCT_LSB:pxct_pkg::PXCT_MSB]     pxct,
   output int                                               n_tests,
   output int                                               n_err
);
   import pxct_pkg::*;

   // Vector op codes
   localparam logic [3:0] OP_STATUS = 4'd0;
   localparam logic [3:0] OP_WR     = 4'd1;
   localparam logic [3:0] OP_RD     = 4'd2;
   localparam logic [3:0] OP_LOAD   = 4'd3;
   localparam logic [3:0] OP_REF    = 4'd4;

   logic              pend;             // Record due this cycle
   logic [3:0]        p_op;
   int                p_id;
   logic [7:0]        p_x;
   logic [3:0]        p_y;
   logic [ADDR_W-1:0] p_z;
   logic              bad;              // Current test hit a mismatch
   int                n_fail;

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      if (act_v !== exp_v)
      begin
         $display("mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
         n_err = n_err + 1;
         bad   = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare one cycle after the DUT took the stimulus
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (rst)
      begin
         pend    <= 1'b0;
         n_tests = 0;
         n_fail  = 0;
         n_err   = 0;
      end
      else
      begin
         bad = 1'b0;
         // Ack and valid only where a record calls for them
         check_val("wb_ack", 32'(pend && (p_op == OP_WR || p_op == OP_RD)), 32'(wb_ack));
         check_val("map_valid", 32'(pend && p_op == OP_REF), 32'(map_valid));
         if (pend)
         begin
            case (p_op)
               OP_RD : check_val("wb_dat_r", 32'(p_x), 32'(wb_dat_r));
               OP_STATUS,
               OP_LOAD :
               begin
                  check_val("pxct_on", 32'(p_x[0]), 32'(pxct_on));
                  check_val("pxct", 32'(p_y), 32'(pxct));
               end
               OP_REF :
               begin
                  check_val("map_user", 32'(p_x[0]), 32'(map_user));
                  check_val("map_ac", 32'(p_y[0]), 32'(map_ac));
                  check_val("map_addr", 32'(p_z), 32'(map_addr));
               end
               default : ;                      // Write, ack only
            endcase
            n_tests = n_tests + 1;
            if (bad)
               n_fail = n_fail + 1;
            $display("test %0d op %0d %s", p_id, p_op, bad ? "FAILED" : "passed");
         end
         pend <= exp_stb;                       // Latch next record
         p_op <= exp_op;
         p_id <= exp_id;
         p_x  <= exp_x;
         p_y  <= exp_y;
         p_z  <= exp_z;
      end
      if (report)
         $display("tests %0d, failed %0d, errors %0d", n_tests, n_fail, n_err);
   end

endmodule

// ==== bench/tb_pxct_unit.sv ====
`timescale 1ns/1ps

module tb_pxct_unit;
   import pxct_pkg::*;

   localparam int    RST_CYCLES = 10;
   localparam int    MAX_VEC    = 64;
   localparam int    N_COL      = 9;    // op a b c d e x y z
   localparam string VEC_FILE   = "bench/pxct_vectors.txt";

   // Vector op codes
   localparam logic [3:0] OP_WR   = 4'd1;
   localparam logic [3:0] OP_RD   = 4'd2;
   localparam logic [3:0] OP_LOAD = 4'd3;
   localparam logic [3:0] OP_REF  = 4'd4;

   logic                     clk = 1'b0;
   logic                     rst;
   logic                     clken;
   logic                     spec_en10;
   logic                     spec_en20;
   spec_sel_e                spec_sel;
   logic [0:DP_W-1]          dp;
   logic                     mem_req;
   logic [ADDR_W-1:0]        mem_addr;
   ref_sel_e                 ref_sel;
   logic                     wru_cycle;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [WB_AW-1:0]         wb_adr;
   logic [WB_DW-1:0]         wb_dat_w;
   logic [WB_DW-1:0]         wb_dat_r;
   logic                     wb_ack;
   logic                     map_valid;
   logic [ADDR_W-1:0]        map_addr;
   logic                     map_user;
   logic                     map_ac;
   logic                     pxct_on;
   logic [PXCT_LSB:PXCT_MSB] pxct;

   // Record handed to the checker
   logic                     exp_stb;
   logic [3:0]               exp_op;
   int                       exp_id;
   logic [7:0]               exp_x;
   logic [3:0]               exp_y;
   logic [ADDR_W-1:0]        exp_z;
   logic                     report;
   int                       n_tests;
   int                       n_err;

   logic [31:0]              vec [0:MAX_VEC-1][0:N_COL-1];
   int                       n_vec = 0;
   logic                     vec_ready = 1'b0;

   always #10 clk = ~clk;               // 20 ns period

   pxct_unit u_dut
   (
      .clk (clk), .rst (rst), .clken (clken),
      .spec_en10 (spec_en10), .spec_en20 (spec_en20), .spec_sel (spec_sel), .dp (dp),
      .mem_req (mem_req), .mem_addr (mem_addr), .ref_sel (ref_sel), .wru_cycle (wru_cycle),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .map_valid (map_valid), .map_addr (map_addr), .map_user (map_user), .map_ac (map_ac),
      .pxct_on (pxct_on), .pxct (pxct)
   );

   pxct_checker u_chk
   (
      .clk (clk), .rst (rst), .report (report),
      .exp_stb (exp_stb), .exp_op (exp_op), .exp_id (exp_id),
      .exp_x (exp_x), .exp_y (exp_y), .exp_z (exp_z),
      .wb_ack (wb_ack), .wb_dat_r (wb_dat_r),
      .map_valid (map_valid), .map_addr (map_addr), .map_user (map_user), .map_ac (map_ac),
      .pxct_on (pxct_on), .pxct (pxct),
      .n_tests (n_tests), .n_err (n_err)
   );

   // Vector column code to selector: 1 PXCTEN, 2 PXCTOFF
   function automatic spec_sel_e spec_code(input logic [1:0] code);
      case (code)
         2'd1    : return SPEC_PXCTEN;
         2'd2    : return SPEC_PXCTOFF;
         default : return SPEC_NOP;
      endcase
   endfunction

   task automatic drive_idle();
      clken     <= 1'b1;
      spec_en10 <= 1'b0;
      spec_en20 <= 1'b0;
      spec_sel  <= SPEC_NOP;
      mem_req   <= 1'b0;
      wru_cycle <= 1'b0;
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      exp_stb   <= 1'b0;
   endtask

   task automatic post_expect(input int idx);
      exp_stb <= 1'b1;
      exp_op  <= vec[idx][0][3:0];
      exp_id  <= idx;
      exp_x   <= vec[idx][6][7:0];
      exp_y   <= vec[idx][7][3:0];
      exp_z   <= vec[idx][8][ADDR_W-1:0];
   endtask

   task automatic wb_access(input int idx);
      @(posedge clk);
      drive_idle();
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= (vec[idx][0][3:0] == OP_WR);
      wb_adr   <= vec[idx][1][WB_AW-1:0];
      wb_dat_w <= vec[idx][2][WB_DW-1:0];
      post_expect(idx);
      @(posedge clk);
      exp_stb <= 1'b0;
      while (!wb_ack)                   // Hold stb until the slave answers
         @(posedge clk);
      drive_idle();
   endtask

   task automatic pxct_load(input int idx);
      logic [0:DP_W-1] dp_v;
      dp_v = DP_W'({$urandom(), $urandom()});   // Noise outside the mask
      dp_v[PXCT_LSB:PXCT_MSB] = vec[idx][5][3:0];
      @(posedge clk);
      drive_idle();
      clken     <= vec[idx][1][0];
      spec_en10 <= vec[idx][2][0];
      spec_en20 <= vec[idx][3][0];
      spec_sel  <= spec_code(vec[idx][4][1:0]);
      dp        <= dp_v;
      post_expect(idx);
   endtask

   task automatic mem_ref(input int idx);
      @(posedge clk);
      drive_idle();
      mem_req   <= 1'b1;
      ref_sel   <= ref_sel_e'(vec[idx][1][2:0]);
      wru_cycle <= vec[idx][2][0];
      mem_addr  <= vec[idx][3][ADDR_W-1:0];
      post_expect(idx);
   endtask

   task automatic run_vector(input int idx);
      case (vec[idx][0][3:0])
         OP_WR,
         OP_RD   : wb_access(idx);
         OP_LOAD : pxct_load(idx);
         OP_REF  : mem_ref(idx);
         default :
         begin
            @(posedge clk);             // Status check only
            drive_idle();
            post_expect(idx);
         end
      endcase
      // Chained references go out on the very next cycle
      if (!(vec[idx][0][3:0] == OP_REF && vec[idx][4][0]))
      begin
         @(posedge clk);
         drive_idle();
         repeat ($urandom_range(3, 0)) @(posedge clk);
      end
   endtask

   task automatic load_vectors(output bit ok);
      int          fd;
      int          cnt;
      string       line;
      logic [31:0] f [0:N_COL-1];
      ok = 1'b1;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0)
      begin
         $display("Cannot open vector file %s", VEC_FILE);
         ok = 1'b0;
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() < 2 || line[0] == "#")
               continue;                // Blank or column notes
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (cnt != N_COL || n_vec >= MAX_VEC)
            begin
               $display("Bad or surplus vector line: %s", line);
               ok = 1'b0;
            end
            else
            begin
               for (int c = 0; c < N_COL; c++)
                  vec[n_vec][c] = f[c];
               n_vec++;
            end
         end
         $fclose(fd);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      bit ok;
      void'($urandom(32'hbee7));
      rst       = 1'b1;
      clken     = 1'b1;
      spec_en10 = 1'b0;
      spec_en20 = 1'b0;
      spec_sel  = SPEC_NOP;
      dp        = '0;
      mem_req   = 1'b0;
      mem_addr  = '0;
      ref_sel   = REF_CURRENT;
      wru_cycle = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      exp_stb   = 1'b0;
      exp_op    = '0;
      exp_id    = 0;
      exp_x     = '0;
      exp_y     = '0;
      exp_z     = '0;
      report    = 1'b0;
      load_vectors(ok);
      if (!ok)
      begin
         $display("Something failed");
         $finish;
      end
      else
      begin
         vec_ready = 1'b1;
         repeat (RST_CYCLES) @(posedge clk);
         rst <= 1'b0;
         for (int i = 0; i < n_vec; i++)
            run_vector(i);
         repeat (3) @(posedge clk);     // Drain the last compare
         report <= 1'b1;
         @(posedge clk);
         report <= 1'b0;
         @(posedge clk);
         if (n_err == 0 && n_tests == n_vec)
            $display("Everything OK");
         else
         begin
            if (n_tests != n_vec)
               $display("Only %0d of %0d tests were checked", n_tests, n_vec);
            $display("Something failed");
         end
         $finish;
      end
   end

   // Watchdog, 20 cycles per vector plus reset
   initial
   begin
      wait (vec_ready);
      repeat (n_vec * 20 + RST_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles", n_vec * 20 + RST_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== bench/pxct_vectors.txt ====
# op a b c d e x y z, hex. op 0 status x=pxct_on y=pxct; 1 wb write a=adr b=data; 2 wb read a=adr x=data
# op 3 load a=clken b=en10 c=en20 d=sel(1 en 2 off) e=mask x=on y=pxct; 4 ref a=ref_sel b=wru c=addr d=chain x=user y=ac z=addr
0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0
2 1 0 0 0 0 0 0 0
1 0 fa 0 0 0 0 0 0
1 1 35 0 0 0 0 0 0
1 2 ff 0 0 0 0 0 0
2 0 0 0 0 0 0a 0 0
2 1 0 0 0 0 05 0 0
2 2 0 0 0 0 0 0 0
2 3 0 0 0 0 0 0 0
4 1 0 5 0 0 1 1 25
3 1 1 0 1 f 1 f 0
3 0 1 0 1 3 1 f 0
3 1 0 1 2 6 0 6 0
4 3 1 4 0 0 1 1 24
3 1 1 0 1 7 1 7 0
4 0 1 0 0 0 1 1 20
4 1 1 1 0 0 1 1 21
4 2 1 2 0 0 0 1 52
4 3 1 100 0 0 0 0 100
4 4 1 f 0 0 0 1 5f
4 5 1 10 0 0 0 0 10
4 6 1 3ffff 0 0 0 0 3ffff
4 7 1 7 0 0 0 1 57
4 3 0 3 0 0 1 1 23
4 7 0 20 0 0 1 0 20
3 1 1 0 1 a 1 a 0
4 0 0 8 1 0 1 1 28
4 1 0 9 1 0 0 1 59
4 2 0 a 1 0 1 1 2a
4 3 0 11 1 0 1 0 11
4 4 0 c 1 0 0 1 5c
4 5 0 d 1 0 0 1 5d
4 6 0 1234 1 0 1 0 1234
4 7 0 e 0 0 1 1 2e
4 1 1 4 0 0 0 1 54
4 6 1 6 0 0 1 1 26
0 0 0 0 0 0 1 a 0

// ==== sim.f ====
hdl/pxct_pkg.sv
hdl/pxct_ctl.sv
hdl/ctx_regs.sv
hdl/ctx_map.sv
hdl/pxct_unit.sv
bench/pxct_checker.sv
bench/tb_pxct_unit.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_pxct_unit
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
FAIL_MSG   := Something failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "Simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
